// ==== vector_exec.f ====
+incdir+tb
common/vec_isa_pkg.sv
common/aes_pkg.sv
hdl/byte_alu.sv
aes/aes_mix_columns.sv
aes/aes_key_word.sv
hdl/vector_alu.sv
hdl/vector_regfile.sv
hdl/vector_exec.sv
tb/tb_vector_exec.sv

// ==== Makefile ====
# Verilator build and run for the vector execute stage

VERILATOR ?= verilator
TOP ?= tb_vector_exec
FILELIST ?= vector_exec.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_PATTERN ?= Result: FAILED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "Simulation reported failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/vec_ref_model.svh ====
// Expected register contents, updated on every load and every defined issue
logic [vec_width-1:0] model_regs [reg_count];

function automatic void clear_model();
	for (int r = 0; r < reg_count; r++) begin
		model_regs[r] = '0;
	end
endfunction

// Opcodes that produce a result and write rd
function automatic bit op_known(input logic [op_width-1:0] code);
	case (code)
		op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl: return 1'b1;
		op_add_round_key, op_shift_rows, op_mix_columns, op_rot_word, op_rcon: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// One byte lane, done in integer arithmetic modulo 256
function automatic logic [7:0] lane_ref(input vec_op_e code, input logic [7:0] a,
	input logic [7:0] b);
	int amount;
	amount = int'(b[2:0]);
	case (code)
		op_add: return 8'((int'(a) + int'(b)) % 256);
		op_sub: return 8'((int'(a) - int'(b) + 256) % 256);
		op_and: return a & b;
		op_or: return a | b;
		op_xor: return a ^ b;
		op_sll: return 8'((int'(a) * (1 << amount)) % 256);
		op_srl: return 8'(int'(a) / (1 << amount));
		default: return 8'h00;
	endcase
endfunction

function automatic logic [vec_width-1:0] lanes_ref(input vec_op_e code,
	input logic [vec_width-1:0] a, input logic [vec_width-1:0] b);
	logic [vec_width-1:0] y;
	for (int k = 0; k < lane_count; k++) begin
		y[8*k +: 8] = lane_ref(code, a[8*k +: 8], b[8*k +: 8]);
	end
	return y;
endfunction

// New column c takes row r from old column c + r
function automatic logic [vec_width-1:0] shift_rows_ref(input logic [vec_width-1:0] s);
	logic [vec_width-1:0] y;
	for (int c = 0; c < state_words; c++) begin
		for (int r = 0; r < state_rows; r++) begin
			y[32*c + 8*r +: 8] = s[32*((c + r) % state_words) + 8*r +: 8];
		end
	end
	return y;
endfunction

function automatic logic [7:0] gf_double(input logic [7:0] x);
	logic [7:0] y;
	y = x << 1;
	if (x[7]) begin
		y = y ^ gf_poly; // Reduce back into the field
	end
	return y;
endfunction

function automatic logic [vec_width-1:0] mix_columns_ref(input logic [vec_width-1:0] s);
	logic [vec_width-1:0] y;
	logic [7:0] b [4];
	for (int c = 0; c < state_words; c++) begin
		for (int r = 0; r < 4; r++) begin
			b[r] = s[32*c + 8*r +: 8];
		end
		// Row r is 2*b[r] + 3*b[r+1] + b[r+2] + b[r+3]
		for (int r = 0; r < 4; r++) begin
			y[32*c + 8*r +: 8] = gf_double(b[r]) ^ gf_double(b[(r + 1) % 4])
				^ b[(r + 1) % 4] ^ b[(r + 2) % 4] ^ b[(r + 3) % 4];
		end
	end
	return y;
endfunction

function automatic logic [vec_width-1:0] rot_word_ref(input logic [vec_width-1:0] s);
	logic [vec_width-1:0] y;
	for (int c = 0; c < state_words; c++) begin
		for (int r = 0; r < 4; r++) begin
			y[32*c + 8*r +: 8] = s[32*c + 8*((r + 1) % 4) +: 8];
		end
	end
	return y;
endfunction

function automatic logic [vec_width-1:0] rcon_ref(input logic [vec_width-1:0] s,
	input logic [3:0] round);
	logic [vec_width-1:0] y;
	logic [7:0] rc;
	rc = (round < 4'(rcon_count)) ? rcon_table[round] : 8'h00;
	y = s;
	for (int c = 0; c < state_words; c++) begin
		y[32*c +: 8] = y[32*c +: 8] ^ rc; // Row 0 of each word
	end
	return y;
endfunction

function automatic logic [vec_width-1:0] exec_ref(input vec_op_e code,
	input logic [vec_width-1:0] a, input logic [vec_width-1:0] b);
	case (code)
		op_add_round_key: return a ^ b;
		op_shift_rows: return shift_rows_ref(a);
		op_mix_columns: return mix_columns_ref(a);
		op_rot_word: return rot_word_ref(a);
		op_rcon: return rcon_ref(a, b[3:0]);
		default: return op_known(code) ? lanes_ref(code, a, b) : '0;
	endcase
endfunction

// ==== tb/tb_vector_exec.sv ====
module tb_vector_exec;
	import vec_isa_pkg::*;
	import aes_pkg::*;

	localparam int clk_period = 4;
	localparam int rand_seed = 7479;
	localparam logic [3:0] zero_reg = 4'd15; // Kept at zero for read back
	localparam logic [3:0] round_reg = 4'd14;
	localparam int n_scalar = 200;
	localparam int n_aes = 60;
	localparam int n_key = 64;
	localparam int n_nop = 24;
	localparam int n_chain = 16;
	localparam int total_cycles = 2 + (2 * reg_count) + (n_scalar + n_scalar / 8 + 1)
		+ (reg_count + n_aes + 3) + (2 * n_key + 1) + (4 * n_nop) + (n_chain + 1);
	localparam int watchdog_time = (total_cycles + 50) * clk_period;
	localparam vec_op_e scalar_ops [7] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl};
	localparam vec_op_e aes_ops [3] = '{op_add_round_key, op_shift_rows, op_mix_columns};

	logic clk;
	logic rst_n;
	logic issue;
	vec_op_e op;
	logic [reg_addr_width-1:0] rd;
	logic [reg_addr_width-1:0] rs1;
	logic [reg_addr_width-1:0] rs2;
	logic load_en;
	logic [reg_addr_width-1:0] load_addr;
	logic [vec_width-1:0] load_data;
	logic [vec_width-1:0] result;
	logic result_valid;

	vector_exec UUT (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.op(op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.result(result),
		.result_valid(result_valid)
	);

	`include "vec_ref_model.svh"

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [vec_width-1:0] expected,
		input logic [vec_width-1:0] actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic logic [vec_width-1:0] random_vec();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	function automatic logic [3:0] random_reg(input int limit);
		return 4'($urandom % limit);
	endfunction

	// All tasks start and end 1 time unit after a rising edge
	task automatic load_reg(input logic [3:0] addr, input logic [vec_width-1:0] data);
		issue = 1'b0;
		load_en = 1'b1;
		load_addr = addr;
		load_data = data;
		@(posedge clk);
		#1;
		check_value("result_valid", '0, result_valid); // No pulse without an issue
		model_regs[addr] = data;
	endtask

	task automatic issue_op(input vec_op_e code, input logic [3:0] dst, input logic [3:0] s1,
		input logic [3:0] s2);
		logic [vec_width-1:0] expected;
		expected = exec_ref(code, model_regs[s1], model_regs[s2]);
		load_en = 1'b0;
		issue = 1'b1;
		op = code;
		rd = dst;
		rs1 = s1;
		rs2 = s2;
		@(posedge clk);
		#1;
		check_value("result_valid", 1, result_valid);
		check_value("result", expected, result);
		if (op_known(code)) begin
			model_regs[dst] = expected;
		end
	endtask

	task automatic idle_cycle();
		issue = 1'b0;
		load_en = 1'b0;
		@(posedge clk);
		#1;
		check_value("result_valid", '0, result_valid);
	endtask

	// OR with the zero register copies rd onto result
	task automatic read_back(input logic [3:0] r);
		issue_op(op_or, r, r, zero_reg);
	endtask

	task automatic reload_regs();
		for (int r = 0; r < reg_count - 1; r++) begin
			load_reg(4'(r), random_vec());
		end
	endtask

	initial begin
		#(watchdog_time);
		$display("Run timed out at %0t before the test sequence finished", $time);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic [3:0] dst;
		logic [3:0] prev;
		logic [4:0] raw;
		logic [vec_width-1:0] vec;
		void'($urandom(rand_seed));
		clk = 1'b0;
		rst_n = 1'b0;
		issue = 1'b0;
		op = nop;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		clear_model();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("result_valid", '0, result_valid);
		check_value("result", '0, result);

		load_reg(zero_reg, '0);
		reload_regs();
		for (int r = 0; r < reg_count - 1; r++) begin
			read_back(4'(r));
		end
		idle_cycle();

		// Random lane ops, issued back to back
		for (int i = 0; i < n_scalar; i++) begin
			dst = random_reg(15);
			issue_op(scalar_ops[$urandom % 7], dst, random_reg(15), random_reg(15));
			if (i % 8 == 7) begin
				read_back(dst);
			end
		end
		idle_cycle();

		reload_regs();
		for (int i = 0; i < n_aes; i++) begin
			issue_op(aes_ops[$urandom % 3], random_reg(15), random_reg(15), random_reg(15));
		end
		vec = random_vec();
		vec[31:0] = 32'h4553_13db; // Column db 13 53 45
		load_reg(4'd0, vec);
		issue_op(op_mix_columns, 4'd1, 4'd0, zero_reg);
		check_value("result column 0", 32'hbca1_4d8e, result[31:0]);
		idle_cycle();

		// Round number in the low nibble of round_reg, up to 15
		for (int i = 0; i < n_key; i++) begin
			vec = random_vec();
			vec[3:0] = 4'($urandom % 16);
			load_reg(round_reg, vec);
			issue_op((i % 2 == 1) ? op_rcon : op_rot_word, random_reg(14), random_reg(14),
				round_reg);
		end
		idle_cycle();

		for (int i = 0; i < n_nop; i++) begin
			raw = 5'b00000;
			if (i > 0) begin
				do begin
					raw = 5'($urandom % 32);
				end while (op_known(raw));
			end
			dst = random_reg(15);
			issue_op(vec_op_e'(raw), dst, random_reg(15), random_reg(15));
			idle_cycle();
			read_back(dst);
			idle_cycle();
		end

		// Each instruction reads the register written just before it
		prev = random_reg(15);
		for (int i = 0; i < n_chain; i++) begin
			dst = random_reg(15);
			issue_op(scalar_ops[$urandom % 7], dst, prev, random_reg(15));
			prev = dst;
		end
		idle_cycle();

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== hdl/vector_exec.sv ====
module vector_exec (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input vec_isa_pkg::vec_op_e op,
	input logic [vec_isa_pkg::reg_addr_width-1:0] rd,
	input logic [vec_isa_pkg::reg_addr_width-1:0] rs1,
	input logic [vec_isa_pkg::reg_addr_width-1:0] rs2,
	input logic load_en,
	input logic [vec_isa_pkg::reg_addr_width-1:0] load_addr,
	input logic [vec_isa_pkg::vec_width-1:0] load_data,
	output logic [vec_isa_pkg::vec_width-1:0] result,
	output logic result_valid
);
	import vec_isa_pkg::*;

	logic [vec_width-1:0] rs1_data;
	logic [vec_width-1:0] rs2_data;
	logic [vec_width-1:0] alu_result;
	logic op_defined;
	logic we;
	logic [reg_addr_width-1:0] waddr;
	logic [vec_width-1:0] wdata;

	// Issue owns the write port, nop and undefined codes write nothing
	assign we = issue ? op_defined : load_en;
	assign waddr = issue ? rd : load_addr;
	assign wdata = issue ? alu_result : load_data;

	vector_regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.raddr_a(rs1),
		.raddr_b(rs2),
		.rdata_a(rs1_data),
		.rdata_b(rs2_data)
	);

	vector_alu u_alu (
		.op(op),
		.src_a(rs1_data),
		.src_b(rs2_data),
		.result(alu_result),
		.op_defined(op_defined)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= issue; // One pulse per issue
			if (issue) begin
				result <= alu_result;
			end
		end
	end

	// Load port is only a stand-in for memory, never shares a cycle with issue
	a_no_issue_with_load: assert property (@(posedge clk) disable iff (!rst_n)
		!(issue && load_en))
		else $error("Issue and load in the same cycle");

endmodule

// ==== hdl/vector_regfile.sv ====
module vector_regfile (
	input logic clk,
	input logic rst_n,
	input logic we,
	input logic [vec_isa_pkg::reg_addr_width-1:0] waddr,
	input logic [vec_isa_pkg::vec_width-1:0] wdata,
	input logic [vec_isa_pkg::reg_addr_width-1:0] raddr_a,
	input logic [vec_isa_pkg::reg_addr_width-1:0] raddr_b,
	output logic [vec_isa_pkg::vec_width-1:0] rdata_a,
	output logic [vec_isa_pkg::vec_width-1:0] rdata_b
);
	import vec_isa_pkg::*;

	logic [vec_width-1:0] regs [reg_count];

	// Every register comes out of reset as zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Combinational reads, old value during a write
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	// Unknown address would smear X over the whole array
	a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(waddr))
		else $error("Register write with unknown address");

endmodule

// ==== hdl/vector_alu.sv ====
module vector_alu (
	input vec_isa_pkg::vec_op_e op,
	input logic [vec_isa_pkg::vec_width-1:0] src_a,
	input logic [vec_isa_pkg::vec_width-1:0] src_b,
	output logic [vec_isa_pkg::vec_width-1:0] result,
	output logic op_defined
);
	import vec_isa_pkg::*;
	import aes_pkg::*;

	logic [vec_width-1:0] lane_result;
	logic [vec_width-1:0] add_round_key_result;
	logic [vec_width-1:0] shift_rows_result;
	logic [vec_width-1:0] mix_columns_result;
	logic [vec_width-1:0] rot_word_result;
	logic [vec_width-1:0] rcon_result;

	// Source byte for ShiftRows, row r moves left by r columns
	function automatic int shift_rows_src(input int k);
		int col;
		int row;
		col = k / state_rows;
		row = k % state_rows;
		shift_rows_src = state_rows * ((col + row) % state_words) + row;
	endfunction

	// All lanes share one opcode
	for (genvar i = 0; i < lane_count; i++) begin : g_lane
		byte_alu u_lane (
			.op(op),
			.a(src_a[lane_width*i +: lane_width]),
			.b(src_b[lane_width*i +: lane_width]),
			.y(lane_result[lane_width*i +: lane_width])
		);
	end

	assign add_round_key_result = src_a ^ src_b;

	for (genvar k = 0; k < state_bytes; k++) begin : g_shift_rows
		assign shift_rows_result[byte_width*k +: byte_width] =
			src_a[byte_width*shift_rows_src(k) +: byte_width];
	end

	aes_mix_columns u_mix_columns (
		.state_in(src_a),
		.state_out(mix_columns_result)
	);

	aes_key_word u_key_word (
		.state_in(src_a),
		.round(src_b[round_width-1:0]), // Round number rides in src_b
		.rot_out(rot_word_result),
		.rcon_out(rcon_result)
	);

	always_comb begin
		result = '0;
		op_defined = 1'b1;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl: begin
				result = lane_result;
			end
			op_add_round_key: result = add_round_key_result;
			op_shift_rows: result = shift_rows_result;
			op_mix_columns: result = mix_columns_result;
			op_rot_word: result = rot_word_result;
			op_rcon: result = rcon_result;
			default: op_defined = 1'b0; // nop and unused codes
		endcase
	end

endmodule

// ==== aes/aes_key_word.sv ====
module aes_key_word (
	input logic [vec_isa_pkg::vec_width-1:0] state_in,
	input logic [aes_pkg::round_width-1:0] round,
	output logic [vec_isa_pkg::vec_width-1:0] rot_out,
	output logic [vec_isa_pkg::vec_width-1:0] rcon_out
);
	import aes_pkg::*;

	logic [byte_width-1:0] rcon_byte;

	// No round constant past the last round
	always_comb begin
		if (round < rcon_count) begin
			rcon_byte = rcon_table[round];
		end else begin
			rcon_byte = '0;
		end
	end

	for (genvar w = 0; w < state_words; w++) begin : g_word
		logic [word_width-1:0] word;

		assign word = state_in[word_width*w +: word_width];

		// RotWord, row 0 takes row 1 and row 3 takes row 0
		assign rot_out[word_width*w +: word_width] =
			{word[byte_width-1:0], word[word_width-1:byte_width]};

		// Rcon lands in row 0 only
		assign rcon_out[word_width*w +: word_width] =
			word ^ {{(word_width-byte_width){1'b0}}, rcon_byte};
	end

endmodule

// ==== aes/aes_mix_columns.sv ====
module aes_mix_columns (
	input logic [vec_isa_pkg::vec_width-1:0] state_in,
	output logic [vec_isa_pkg::vec_width-1:0] state_out
);
	import aes_pkg::*;

	// Multiply by x in GF(2^8)
	function automatic logic [byte_width-1:0] xtime(input logic [byte_width-1:0] x);
		xtime = {x[byte_width-2:0], 1'b0} ^ (x[byte_width-1] ? gf_poly : '0);
	endfunction

	for (genvar c = 0; c < state_words; c++) begin : g_col
		logic [byte_width-1:0] s0, s1, s2, s3;
		logic [byte_width-1:0] x0, x1, x2, x3; // 2 * s

		assign s0 = state_in[word_width*c +: byte_width];
		assign s1 = state_in[word_width*c + byte_width +: byte_width];
		assign s2 = state_in[word_width*c + 2*byte_width +: byte_width];
		assign s3 = state_in[word_width*c + 3*byte_width +: byte_width];

		assign x0 = xtime(s0);
		assign x1 = xtime(s1);
		assign x2 = xtime(s2);
		assign x3 = xtime(s3);

		// Rows of the 02 03 01 01 circulant, 3s = 2s ^ s
		assign state_out[word_width*c +: byte_width] = x0 ^ x1 ^ s1 ^ s2 ^ s3;
		assign state_out[word_width*c + byte_width +: byte_width] = s0 ^ x1 ^ x2 ^ s2 ^ s3;
		assign state_out[word_width*c + 2*byte_width +: byte_width] = s0 ^ s1 ^ x2 ^ x3 ^ s3;
		assign state_out[word_width*c + 3*byte_width +: byte_width] = x0 ^ s0 ^ s1 ^ s2 ^ x3;
	end

	// FIPS-197 test column db 13 53 45 maps to 8e 4d a1 bc
	// Sampled on any change of the output, so each settled pair is seen
	a_known_column: assert property (@(state_out)
		(state_in[word_width-1:0] == 32'h4553_13db) |->
			(state_out[word_width-1:0] == 32'hbca1_4d8e))
		else $error("MixColumns known column mismatch");

endmodule

// ==== hdl/byte_alu.sv ====
module byte_alu (
	input vec_isa_pkg::vec_op_e op,
	input logic [vec_isa_pkg::lane_width-1:0] a,
	input logic [vec_isa_pkg::lane_width-1:0] b,
	output logic [vec_isa_pkg::lane_width-1:0] y
);
	import vec_isa_pkg::*;

	logic [lane_shift_width-1:0] shamt;

	// Only the low bits of b count for shifts
	assign shamt = b[lane_shift_width-1:0];

	always_comb begin
		case (op)
			op_add: begin
				y = a + b; // Wraps mod 256
			end
			op_sub: begin
				y = a - b;
			end
			op_and: begin
				y = a & b;
			end
			op_or: begin
				y = a | b;
			end
			op_xor: begin
				y = a ^ b;
			end
			op_sll: begin
				y = a << shamt;
			end
			op_srl: begin
				y = a >> shamt; // Logical, zero fill
			end
			default: begin
				// AES codes and nop are handled above the lanes
				y = '0;
			end
		endcase
	end

endmodule

// ==== common/aes_pkg.sv ====
package aes_pkg;

	localparam int byte_width = 8;
	localparam int word_width = 32;

	// State is 4 x 4 bytes, column major
	localparam int state_bytes = 16;
	localparam int state_words = 4;  // Columns
	localparam int state_rows = 4;   // Bytes per column

	// xtime reduction, x^8 + x^4 + x^3 + x + 1
	localparam logic [byte_width-1:0] gf_poly = 8'h1b;

	// Key schedule round number from the low bits of src_b
	localparam int round_width = 4;
	localparam int rcon_count = 10;

	// Round constants, entry 0 is the first round
	localparam logic [byte_width-1:0] rcon_table [0:rcon_count-1] = '{
		8'h01,
		8'h02,
		8'h04,
		8'h08,
		8'h10,
		8'h20,
		8'h40,
		8'h80,
		8'h1b,
		8'h36
	};

endpackage

// ==== common/vec_isa_pkg.sv ====
package vec_isa_pkg;

	// Datapath geometry
	localparam int vec_width = 128;
	localparam int lane_width = 8;
	localparam int lane_count = vec_width / lane_width;  // 16 byte lanes
	localparam int lane_shift_width = $clog2(lane_width); // Shift amount bits per lane

	// Register file
	localparam int reg_count = 16;
	localparam int reg_addr_width = $clog2(reg_count);

	localparam int op_width = 5;

	// Vector opcodes, scalar lane ops in the low codes
	typedef enum logic [op_width-1:0] {
		nop = 5'b00000,
		op_add = 5'b00001,
		op_sub = 5'b00010,
		op_and = 5'b00011,
		op_or = 5'b00100,
		op_xor = 5'b00101,
		op_sll = 5'b00110, // Per byte, by low bits of src_b byte
		op_srl = 5'b00111,

		// AES round operations
		op_add_round_key = 5'b10011,
		op_shift_rows = 5'b10100,
		op_mix_columns = 5'b10101,
		op_rot_word = 5'b10110,
		op_rcon = 5'b10111
	} vec_op_e;

endpackage
